//--- sources.f
logic/soc_pkg.sv
logic/mem_bus_if.sv
logic/boot_rom.sv
logic/rv_core.sv
logic/system_bus.sv
logic/ps2_receiver.sv
logic/keyboard_soc.sv
verification/tb_clock.sv
verification/soc_tb.sv

//--- Bender.yml
package:
  name: keyboard_soc

sources:
  - logic/soc_pkg.sv
  - logic/mem_bus_if.sv
  - logic/boot_rom.sv
  - logic/rv_core.sv
  - logic/system_bus.sv
  - logic/ps2_receiver.sv
  - logic/keyboard_soc.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/soc_tb.sv

//--- rom.hex
// One 32-bit instruction per line, bytes in little-endian order
B7F0FF7F
9380F07F
9380F07F
13018004
23B12000
93019006
23B13000
37120000
23303200
83320200
93821200
23B15000

//--- verification/soc_tb.sv
module soc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import soc_pkg::*;

    localparam int half_period    = 40;
    localparam int min_gap        = 60;
    localparam int max_gap        = 300;
    localparam int program_length = 12;
    // Two ROM passes plus eight frames with their gaps and some margin
    localparam int timeout_cycles = 20000;

    logic        clk;
    logic        reset;
    logic        ps2_clk;
    logic        ps2_data;
    logic [7:0]  console_data;
    logic        console_write;
    logic [7:0]  ir_view;
    logic        heartbeat;

    logic [7:0]  program_bytes [$];
    logic [7:0]  key_bytes [$];
    logic [7:0]  expected_keys [$];
    logic [7:0]  ir_history [$];
    bit          stall_history [$];
    int          cycle_count = 0;
    int          fetch_count;
    logic        prev_heartbeat;
    int unsigned seed;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    keyboard_soc UUT (
        .clk           (clk),
        .reset         (reset),
        .ps2_clk       (ps2_clk),
        .ps2_data      (ps2_data),
        .console_data  (console_data),
        .console_write (console_write),
        .ir_view       (ir_view),
        .heartbeat     (heartbeat)
    );

    // Low byte of each program word in fetch order
    function automatic logic [7:0] program_low_byte(input int index);
        logic [31:0] word;
        case (index)
            0:       word = 32'h7FFF_F0B7; // lui  x1, 0x7ffff
            1:       word = 32'h7FF0_8093; // addi x1, x1, 2047
            2:       word = 32'h7FF0_8093; // addi x1, x1, 2047
            3:       word = 32'h0480_0113; // addi x2, x0, 'H'
            4:       word = 32'h0020_B123; // sd   x2, 2(x1)
            5:       word = 32'h0690_0193; // addi x3, x0, 'i'
            6:       word = 32'h0030_B123; // sd   x3, 2(x1)
            7:       word = 32'h0000_1237; // lui  x4, 0x1
            8:       word = 32'h0032_3023; // sd   x3, 0(x4)
            9:       word = 32'h0002_3283; // ld   x5, 0(x4)
            10:      word = 32'h0012_8293; // addi x5, x5, 1
            default: word = 32'h0050_B123; // sd   x5, 2(x1)
        endcase
        return word[7:0];
    endfunction

    // Console text of one program pass
    function automatic logic [7:0] program_text(input int index);
        case (index % 3)
            0:       return 8'h48;
            1:       return 8'h69;
            default: return 8'h6A;
        endcase
    endfunction

    function automatic bit is_program_byte(input logic [7:0] value);
        return (value == 8'h48) || (value == 8'h69) || (value == 8'h6A);
    endfunction

    function automatic logic [7:0] random_code();
        logic [7:0] code;
        code = 8'($urandom);
        while ((code == ps2_break_code) || (code == ps2_extend_code) || is_program_byte(code)) begin
            code = 8'($urandom);
        end
        return code;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        fail_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic idle_gap();
        wait_cycles(min_gap + ($urandom % (max_gap - min_gap + 1)));
    endtask

    // Start bit, data LSB first, odd parity and stop bit
    task automatic send_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] bits;
        logic        parity;
        int          i;
        parity = ~(^code);
        if (bad_parity) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, code, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            wait_cycles(half_period);
            ps2_clk = 1'b0;
            wait_cycles(half_period);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic send_key(input logic [7:0] code);
        expected_keys.push_back(code);
        send_frame(code, 1'b0);
    endtask

    task automatic collect_console();
        if (is_program_byte(console_data)) begin
            assert (console_data == program_text(program_bytes.size()))
                else report_value("console_data", console_data,
                                  program_text(program_bytes.size()));
            program_bytes.push_back(console_data);
        end else if (key_bytes.size() >= expected_keys.size()) begin
            fail_run($sformatf("Unexpected key echo 0x%0h on the console", console_data));
        end else begin
            // Echo froze the core for the two cycles before this strobe
            stall_history[stall_history.size() - 2] = 1'b1;
            stall_history[stall_history.size() - 3] = 1'b1;
            assert (console_data == expected_keys[key_bytes.size()])
                else report_value("console_data", console_data, expected_keys[key_bytes.size()]);
            key_bytes.push_back(console_data);
        end
    endtask

    // IR holds the word fetched in the last cycle that was not frozen
    task automatic check_ir_view();
        logic [7:0] observed;
        bit         stalled;
        int         index;
        observed = ir_history.pop_front();
        stalled  = stall_history.pop_front();
        index    = (fetch_count - 1) % rom_words;
        if (!stalled) begin
            if (index < program_length) begin
                assert (observed === program_low_byte(index))
                    else report_value("ir_view", observed, program_low_byte(index));
            end
            fetch_count++;
        end
    endtask

    // Outputs sampled on the falling edge with three cycles of history for stalls
    initial begin
        wait (reset === 1'b1);
        @(posedge clk);
        fetch_count    = 1;
        prev_heartbeat = 1'b0;
        forever begin
            @(negedge clk);
            assert (heartbeat === !prev_heartbeat)
                else report_value("heartbeat", heartbeat, !prev_heartbeat);
            prev_heartbeat = heartbeat;
            ir_history.push_back(ir_view);
            stall_history.push_back(1'b0);
            if (console_write === 1'b1) begin
                collect_console();
            end
            if (ir_history.size() > 3) begin
                check_ir_view();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run("Run did not finish within the cycle limit");
        end
    end

    initial begin
        logic [7:0] code;
        int         target;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        seed     = 32'hdd64;
        void'($urandom(seed));
        @(negedge clk);
        assert (console_write === 1'b0) else report_value("console_write", console_write, 0);
        assert (heartbeat === 1'b0) else report_value("heartbeat", heartbeat, 0);
        wait (reset === 1'b1);

        idle_gap();
        send_key(random_code());

        // Only the code after the extended prefix is echoed
        idle_gap();
        code = random_code();
        expected_keys.push_back(code);
        send_frame(ps2_extend_code, 1'b0);
        idle_gap();
        send_frame(code, 1'b0);

        // Key release
        idle_gap();
        send_frame(ps2_break_code, 1'b0);
        idle_gap();
        send_frame(random_code(), 1'b0);

        // Dropped frame followed by normal traffic
        idle_gap();
        send_frame(random_code(), 1'b1);
        idle_gap();
        send_key(random_code());
        idle_gap();
        send_key(random_code());

        // One more program pass leaves room for a duplicate echo
        while (key_bytes.size() < expected_keys.size()) begin
            @(negedge clk);
        end
        target = program_bytes.size() + 3;
        while (program_bytes.size() < target) begin
            @(negedge clk);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verification/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam real half_period  = 2.0;
    localparam int  reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's active edge
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

endmodule

//--- logic/keyboard_soc.sv
module keyboard_soc (
    input  logic       clk,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] console_data,
    output logic       console_write,
    output logic [7:0] ir_view,
    output logic       heartbeat
);
    import soc_pkg::*;

    logic [addr_width-1:0] pc;
    logic [31:0]           instruction;
    logic [7:0]            key_code;
    logic                  key_make;
    logic                  key_irq;

    mem_bus_if bus ();

    boot_rom u_boot_rom (
        .clk         (clk),
        .pc          (pc),
        .instruction (instruction)
    );

    rv_core u_rv_core (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .key_irq     (key_irq),
        .bus         (bus.master),
        .ir_view     (ir_view),
        .heartbeat   (heartbeat)
    );

    system_bus u_system_bus (
        .clk           (clk),
        .reset         (reset),
        .bus           (bus.target),
        .key_code      (key_code),
        .key_make      (key_make),
        .key_irq       (key_irq),
        .console_data  (console_data),
        .console_write (console_write)
    );

    ps2_receiver u_ps2_receiver (
        .clk      (clk),
        .reset    (reset),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .key_code (key_code),
        .key_make (key_make)
    );

endmodule

//--- logic/ps2_receiver.sv
module ps2_receiver (
    input  logic       clk,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic [7:0] key_code,
    output logic       key_make
);
    import soc_pkg::*;

    localparam int timer_width = $clog2(ps2_timeout_cycles + 1);

    logic [1:0]             clk_sync;
    logic [1:0]             data_sync;
    logic                   clk_prev;
    logic                   clk_fall;
    logic [3:0]             bit_count;
    logic [10:0]            frame;
    logic                   frame_done;
    logic [timer_width-1:0] idle_timer;
    logic [7:0]             frame_code;
    logic                   frame_ok;
    logic                   is_prefix;
    logic                   break_pending;
    logic                   make_ok;

    // Both lines idle high
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    // Start, data LSB first, parity, stop
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            frame <= {data_sync[1], frame[10:1]};
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bit_count  <= '0;
            frame_done <= 1'b0;
            idle_timer <= '0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                idle_timer <= '0;
                if (bit_count == 4'd10) begin
                    bit_count  <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end else if (bit_count != 4'd0) begin
                // Host stopped clocking mid frame
                if (idle_timer == timer_width'(ps2_timeout_cycles - 1)) begin
                    bit_count  <= '0;
                    idle_timer <= '0;
                end else begin
                    idle_timer <= idle_timer + 1'b1;
                end
            end
        end
    end

    // Odd parity over data and parity bit
    assign frame_code = frame[8:1];
    assign frame_ok   = !frame[0] && frame[10] && (^frame[9:1]);
    assign is_prefix  = (frame_code == ps2_break_code) || (frame_code == ps2_extend_code);
    assign make_ok    = frame_done && frame_ok && !is_prefix && !break_pending;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_make      <= 1'b0;
            break_pending <= 1'b0;
        end else begin
            key_make <= make_ok;
            if (frame_done && frame_ok) begin
                if (frame_code == ps2_break_code) begin
                    break_pending <= 1'b1;
                end else if (frame_code != ps2_extend_code) begin
                    // Code after a break is the release
                    break_pending <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (make_ok) begin
            key_code <= frame_code;
        end
    end

endmodule

//--- logic/system_bus.sv
module system_bus (
    input  logic       clk,
    input  logic       reset,
    mem_bus_if.target  bus,
    input  logic [7:0] key_code,
    input  logic       key_make,
    output logic       key_irq,
    output logic [7:0] console_data,
    output logic       console_write
);
    import soc_pkg::*;

    localparam int ram_index_width = $clog2(ram_words);
    localparam int byte_shift      = $clog2(xlen / 8);

    logic [xlen-1:0]            ram [0:ram_words-1];
    logic                       ram_sel;
    logic                       console_sel;
    logic                       key_sel;
    logic [addr_width-1:0]      ram_offset;
    logic [ram_index_width-1:0] ram_index;
    logic [7:0]                 key_value;

    // Address decode
    assign ram_sel     = (bus.address >= ram_base) && (bus.address < ram_base + ram_size);
    assign console_sel = (bus.address == console_base);
    assign key_sel     = (bus.address == key_base);

    // Double word index inside the RAM window
    assign ram_offset = bus.address - ram_base;
    assign ram_index  = ram_offset[ram_index_width+byte_shift-1:byte_shift];

    always_ff @(posedge clk) begin
        if (bus.write_enable && ram_sel) begin
            ram[ram_index] <= bus.write_data;
        end
    end

    // Unmapped reads return zero
    always_comb begin
        bus.read_data = '0;
        if (bus.read_enable) begin
            if (ram_sel) begin
                bus.read_data = ram[ram_index];
            end else if (console_sel) begin
                bus.read_data = {{(xlen-8){1'b0}}, console_data};
            end else if (key_sel) begin
                bus.read_data = {{(xlen-8){1'b0}}, key_value};
            end
        end
    end

    // Console strobe one cycle after the bus write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            console_write <= 1'b0;
        end else begin
            console_write <= bus.write_enable && console_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.write_enable && console_sel) begin
            console_data <= bus.write_data[7:0];
        end
    end

    // A new make code wins over the clearing read
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_irq <= 1'b0;
        end else if (key_make) begin
            key_irq <= 1'b1;
        end else if (bus.read_enable && key_sel) begin
            key_irq <= 1'b0;
        end
    end

    // Latest code only, an unserviced one is overwritten
    always_ff @(posedge clk) begin
        if (key_make) begin
            key_value <= key_code;
        end
    end

endmodule

//--- logic/rv_core.sv
module rv_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    instruction,
    output logic [soc_pkg::addr_width-1:0] pc,
    input  logic                           key_irq,
    mem_bus_if.master                      bus,
    output logic [7:0]                     ir_view,
    output logic                           heartbeat
);
    import soc_pkg::*;

    logic [31:0]     ir;
    logic [xlen-1:0] regs [0:31];

    // Instruction fields
    logic [6:0]      opcode;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;

    logic            is_lui;
    logic            is_addi;
    logic            is_load;
    logic            is_store;

    // Interrupt echo sequence
    logic            echo_read;
    logic            echo_write;
    logic            stall;
    logic [7:0]      echo_byte;

    logic            rd_write;
    logic [xlen-1:0] rd_value;

    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    assign imm_i = {{(xlen-12){ir[31]}}, ir[31:20]};
    assign imm_s = {{(xlen-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{(xlen-32){ir[31]}}, ir[31:12], 12'b0};

    // x0 always reads zero
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Echo cycle 1 reads the key, echo cycle 2 writes the console
    assign echo_read = key_irq && !echo_write;
    assign stall     = echo_read || echo_write;

    // The frozen instruction waits until the echo is done
    assign is_lui   = !stall && (opcode == opcode_lui);
    assign is_addi  = !stall && (opcode == opcode_op_imm) && (funct3 == funct3_addi);
    assign is_load  = !stall && (opcode == opcode_load);
    assign is_store = !stall && (opcode == opcode_store);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc         <= '0;
            ir         <= '0;
            heartbeat  <= 1'b0;
            echo_write <= 1'b0;
        end else begin
            heartbeat  <= ~heartbeat;
            echo_write <= echo_read;
            if (!stall) begin
                pc <= pc + 4;
                ir <= instruction;
            end
        end
    end

    // Key code captured from the bus in echo cycle 1
    always_ff @(posedge clk) begin
        if (echo_read) begin
            echo_byte <= bus.read_data[7:0];
        end
    end

    // Bus requests, echo has priority over the program
    always_comb begin
        bus.address      = '0;
        bus.write_data   = '0;
        bus.write_enable = 1'b0;
        bus.read_enable  = 1'b0;
        if (echo_read) begin
            bus.address     = key_base;
            bus.read_enable = 1'b1;
        end else if (echo_write) begin
            bus.address      = console_base;
            bus.write_data   = {{(xlen-8){1'b0}}, echo_byte};
            bus.write_enable = 1'b1;
        end else if (is_load) begin
            bus.address     = rs1_val + imm_i;
            bus.read_enable = 1'b1;
        end else if (is_store) begin
            bus.address      = rs1_val + imm_s;
            bus.write_data   = rs2_val;
            bus.write_enable = 1'b1;
        end
    end

    // Register write back
    always_comb begin
        rd_write = 1'b0;
        rd_value = '0;
        if (is_lui) begin
            rd_write = 1'b1;
            rd_value = imm_u;
        end else if (is_addi) begin
            rd_write = 1'b1;
            rd_value = rs1_val + imm_i;
        end else if (is_load) begin
            rd_write = 1'b1;
            rd_value = bus.read_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_write && (rd != 5'd0)) begin
            regs[rd] <= rd_value;
        end
    end

    assign ir_view = ir[7:0];

endmodule

//--- logic/boot_rom.sv
module boot_rom (
    input  logic                           clk,
    input  logic [soc_pkg::addr_width-1:0] pc,
    output logic [31:0]                    instruction
);
    import soc_pkg::*;

    localparam int index_width = $clog2(rom_size) - 2;

    logic [31:0]            rom [0:rom_words-1];
    logic [addr_width-1:0]  rom_offset;
    logic [index_width-1:0] word_index;
    logic [31:0]            stored_word;

    initial begin
        $readmemh("rom.hex", rom);
    end

    // Word index inside the window, so the fetch wraps at 4 KB
    assign rom_offset  = pc - rom_base;
    assign word_index  = rom_offset[index_width+1:2];
    assign stored_word = rom[word_index];

    // Image bytes are little-endian
    assign instruction = {
        stored_word[7:0],
        stored_word[15:8],
        stored_word[23:16],
        stored_word[31:24]
    };

endmodule

//--- logic/mem_bus_if.sv
interface mem_bus_if;
    import soc_pkg::*;

    logic [addr_width-1:0] address;
    logic [xlen-1:0]       write_data;
    logic                  write_enable;
    logic                  read_enable;
    logic [xlen-1:0]       read_data;

    // Core side
    modport master (
        output address,
        output write_data,
        output write_enable,
        output read_enable,
        input  read_data
    );

    // Decoder side, read data is combinational
    modport target (
        input  address,
        input  write_data,
        input  write_enable,
        input  read_enable,
        output read_data
    );

endinterface

//--- logic/soc_pkg.sv
package soc_pkg;

    // Datapath and bus widths
    localparam int xlen       = 64;
    localparam int addr_width = 64;

    // Boot ROM window, read only through the fetch port
    localparam logic [addr_width-1:0] rom_base = 64'h0000_0000;
    localparam logic [addr_width-1:0] rom_size = 64'h0000_1000;
    localparam int                    rom_words = 1024;

    // Data RAM window, 1024 double words
    localparam logic [addr_width-1:0] ram_base  = 64'h0000_1000;
    localparam logic [addr_width-1:0] ram_size  = 64'h0000_2000;
    localparam int                    ram_words = 1024;

    // Memory mapped registers
    localparam logic [addr_width-1:0] console_base = 64'h8000_0000;
    localparam logic [addr_width-1:0] key_base     = 64'h8000_0010;

    // Major opcodes the core executes, all others are no-ops
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    // ADDI within the OP-IMM group
    localparam logic [2:0] funct3_addi = 3'b000;

    // PS/2 scan code prefixes
    localparam logic [7:0] ps2_break_code  = 8'hF0;
    localparam logic [7:0] ps2_extend_code = 8'hE0;

    // Cycles without a PS/2 clock edge before a partial frame is dropped
    localparam int ps2_timeout_cycles = 2000;

endpackage
